//--- mem_pkg.sv
// Memory system constants
package mem_pkg;

	// Bus widths
	localparam int AW = 24;
	localparam int DW = 16;

	// Arbiter ports and read burst length
	localparam int NCLIENT = 3;
	localparam int BURST = 8;

	// Client index by priority, lowest wins
	localparam int CL_SCAN = 0;
	localparam int CL_PIX = 1;
	localparam int CL_TEST = 2;

endpackage

//--- video_pkg.sv
// Video pixel formats and frame layout
package video_pkg;
	import mem_pkg::*;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// One stored word, as raw data or as a pixel
	typedef union packed {
		logic [DW-1:0] raw;
		rgb565_t px;
	} pix_word_u;

	// Frame region and self-test region
	localparam logic [AW-1:0] FB_BASE = AW'('h200);
	localparam int FB_WORDS = 64;
	localparam logic [AW-1:0] TEST_BASE = FB_BASE + AW'('h100);
	localparam int TEST_WORDS = 16;

	// Keep the top bits of each channel
	function automatic rgb565_t pack565(input logic [23:0] rgb);
		return '{r: rgb[23:19], g: rgb[15:10], b: rgb[7:3]};
	endfunction

	// Refill the low bits from the top of each channel
	function automatic logic [23:0] expand888(input rgb565_t px);
		return {px.r, px.r[4:2], px.g, px.g[5:4], px.b, px.b[4:2]};
	endfunction

endpackage

//--- mem_array.sv
// On-chip word storage
`timescale 1ns/10ps
module mem_array import mem_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW,
	parameter int DEPTH_LOG2 = 10
) (
	input logic CLOCK_50,
	input logic [AW-1:0] arr_addr,
	input logic arr_we,
	input logic [DW-1:0] arr_wdata,
	output logic [DW-1:0] arr_rdata
);

logic [DW-1:0] mem [2**DEPTH_LOG2];
logic [DEPTH_LOG2-1:0] idx;

// Upper address bits alias onto the array
assign idx = arr_addr[DEPTH_LOG2-1:0];

// Write-first, data one cycle after address
always_ff @(posedge CLOCK_50) begin
	if (arr_we) begin
		mem[idx] <= arr_wdata;
		arr_rdata <= arr_wdata;
	end else
		arr_rdata <= mem[idx];
end

endmodule

//--- memory.sv
// Shared memory arbiter
`timescale 1ns/10ps
module memory import mem_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW,
	parameter int BURST = mem_pkg::BURST,
	parameter int NCLIENT = mem_pkg::NCLIENT
) (
	input logic CLOCK_50,
	input logic rst,
	input logic [NCLIENT-1:0] req,
	input logic [NCLIENT-1:0] wr,
	input logic [NCLIENT-1:0][AW-1:0] addr,
	input logic [NCLIENT-1:0][DW-1:0] wdata,
	output logic [NCLIENT-1:0] ack,
	output logic [NCLIENT-1:0] valid,
	output logic [DW-1:0] rdata,
	output logic [AW-1:0] arr_addr,
	output logic arr_we,
	output logic [DW-1:0] arr_wdata,
	input logic [DW-1:0] arr_rdata
);

localparam int CW = (NCLIENT > 1) ? $clog2(NCLIENT) : 1;
localparam int NW = $clog2(BURST + 2);

localparam logic [1:0] S_IDLE = 2'd0;
localparam logic [1:0] S_ACK = 2'd1;
localparam logic [1:0] S_READ = 2'd2;
localparam logic [1:0] S_DRAIN = 2'd3;

logic [1:0] state;
logic [CW-1:0] gnt;
logic [CW-1:0] pick;
logic [NW-1:0] cnt;
logic [AW-1:0] baddr;
logic rd_issue;
logic tag_v;
logic [CW-1:0] tag_cl;

// Fixed priority, lowest index first
always_comb begin
	pick = '0;
	for (int i = NCLIENT - 1; i >= 0; i--) begin
		if (req[i])
			pick = CW'(i);
	end
end

// Ack cycle uses the client's own address, then the burst counter
always_comb begin
	arr_addr = baddr;
	arr_we = 1'b0;
	if (state == S_ACK) begin
		arr_addr = addr[gnt];
		arr_we = wr[gnt];
	end
end

assign arr_wdata = wdata[gnt];
assign rd_issue = (state == S_ACK && !wr[gnt]) || state == S_READ;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		gnt <= '0;
		ack <= '0;
		cnt <= '0;
	end else begin
		ack <= '0;
		case (state)
		S_IDLE: begin
			if (|req) begin
				gnt <= pick;
				ack[pick] <= 1'b1;
				state <= S_ACK;
			end
		end
		S_ACK: begin
			cnt <= NW'(1);
			if (wr[gnt])
				state <= S_IDLE;
			else if (BURST == 1)
				state <= S_DRAIN;
			else
				state <= S_READ;
		end
		S_READ: begin
			cnt <= cnt + NW'(1);
			if (cnt == NW'(BURST - 1))
				state <= S_DRAIN;
		end
		default: begin
			// Wait out the array and output register latency
			cnt <= cnt + NW'(1);
			if (cnt == NW'(BURST + 1))
				state <= S_IDLE;
		end
		endcase
	end
end

always_ff @(posedge CLOCK_50) begin
	rdata <= arr_rdata;
	tag_cl <= gnt;
	if (state == S_ACK)
		baddr <= addr[gnt] + AW'(1);
	else if (state == S_READ)
		baddr <= baddr + AW'(1);
end

// Tag follows each read through the array and rdata stages
always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		tag_v <= 1'b0;
		valid <= '0;
	end else begin
		tag_v <= rd_issue;
		valid <= '0;
		if (tag_v)
			valid[tag_cl] <= 1'b1;
	end
end

endmodule

//--- pixel_writer.sv
// Pixel input queue and writer
`timescale 1ns/10ps
module pixel_writer import mem_pkg::*, video_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW
) (
	input logic CLOCK_50,
	input logic rst,
	input logic pix_valid,
	input logic [AW-1:0] pix_addr,
	input logic [23:0] pix_rgb,
	input logic ack,
	output logic pix_ready,
	output logic req,
	output logic wr,
	output logic [AW-1:0] addr,
	output logic [DW-1:0] wdata
);

localparam int DEPTH = 4;
localparam int PW = $clog2(DEPTH);

logic [AW-1:0] q_addr [DEPTH];
logic [DW-1:0] q_data [DEPTH];
logic [PW-1:0] wptr;
logic [PW-1:0] rptr;
logic [PW:0] count;
logic push;
logic pop;
pix_word_u word;

assign word.px = pack565(pix_rgb);

assign pix_ready = count != (PW + 1)'(DEPTH);
assign push = pix_valid && pix_ready;
assign pop = req && ack;

// Queue head is the pending write
assign req = count != '0;
assign wr = 1'b1;
assign addr = q_addr[rptr];
assign wdata = q_data[rptr];

always_ff @(posedge CLOCK_50) begin
	if (push) begin
		q_addr[wptr] <= pix_addr;
		q_data[wptr] <= word.raw;
	end
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		wptr <= '0;
		rptr <= '0;
		count <= '0;
	end else begin
		if (push)
			wptr <= wptr + PW'(1);
		if (pop)
			rptr <= rptr + PW'(1);
		count <= count + (PW + 1)'(push) - (PW + 1)'(pop);
	end
end

endmodule

//--- scan_reader.sv
// Frame scan reader
`timescale 1ns/10ps
module scan_reader import mem_pkg::*, video_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW,
	parameter int BURST = mem_pkg::BURST,
	parameter logic [AW-1:0] FB_BASE = video_pkg::FB_BASE,
	parameter int FB_WORDS = video_pkg::FB_WORDS
) (
	input logic CLOCK_50,
	input logic rst,
	input logic scan_start,
	input logic ack,
	input logic valid,
	input logic [DW-1:0] rdata,
	output logic req,
	output logic [AW-1:0] addr,
	output logic scan_busy,
	output logic out_valid,
	output logic [23:0] out_rgb,
	output logic out_last
);

localparam int NBURST = FB_WORDS / BURST;
localparam int BCW = $clog2(NBURST + 1);
localparam int WCW = $clog2(FB_WORDS + 1);

logic [BCW-1:0] bcnt;
logic [WCW-1:0] wcnt;
logic start;
pix_word_u word;

assign word.raw = rdata;
assign start = scan_start && !scan_busy;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		req <= 1'b0;
		scan_busy <= 1'b0;
		bcnt <= '0;
		wcnt <= '0;
		out_valid <= 1'b0;
		out_last <= 1'b0;
	end else begin
		out_valid <= valid;
		out_last <= 1'b0;
		if (start) begin
			scan_busy <= 1'b1;
			req <= 1'b1;
			bcnt <= '0;
			wcnt <= '0;
		end
		// Next burst request goes out right after each ack
		if (req && ack) begin
			bcnt <= bcnt + BCW'(1);
			if (bcnt == BCW'(NBURST - 1))
				req <= 1'b0;
		end
		if (valid) begin
			wcnt <= wcnt + WCW'(1);
			if (wcnt == WCW'(FB_WORDS - 1)) begin
				out_last <= 1'b1;
				scan_busy <= 1'b0;
			end
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (start)
		addr <= FB_BASE;
	else if (req && ack)
		addr <= addr + AW'(BURST);
	if (valid)
		out_rgb <= expand888(word.px);
end

endmodule

//--- mem_test.sv
// Memory self-test client
`timescale 1ns/10ps
module mem_test import mem_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW,
	parameter int BURST = mem_pkg::BURST,
	parameter logic [AW-1:0] TEST_BASE = video_pkg::TEST_BASE,
	parameter int TEST_WORDS = video_pkg::TEST_WORDS
) (
	input logic CLOCK_50,
	input logic rst,
	input logic test_run,
	input logic ack,
	input logic valid,
	input logic [DW-1:0] rdata,
	output logic req,
	output logic wr,
	output logic [AW-1:0] addr,
	output logic [DW-1:0] wdata,
	output logic test_done,
	output logic test_fail
);

localparam logic [DW-1:0] PATTERN = DW'(16'h5A5A);
localparam int NBURST = TEST_WORDS / BURST;
localparam int CW = $clog2(TEST_WORDS + 1);

localparam logic [1:0] P_IDLE = 2'd0;
localparam logic [1:0] P_WRITE = 2'd1;
localparam logic [1:0] P_READ = 2'd2;

logic [1:0] phase;
logic [CW-1:0] cnt;
logic [CW-1:0] chk_cnt;
logic [AW-1:0] chk_addr;
logic [DW-1:0] exp_word;
logic start;
logic last_wr;

// Pattern is a function of the address alone
assign wdata = addr[DW-1:0] ^ PATTERN;
assign exp_word = chk_addr[DW-1:0] ^ PATTERN;
assign start = phase == P_IDLE && test_run;
assign last_wr = cnt == CW'(TEST_WORDS - 1);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		phase <= P_IDLE;
		req <= 1'b0;
		wr <= 1'b0;
		cnt <= '0;
		chk_cnt <= '0;
		test_done <= 1'b0;
		test_fail <= 1'b0;
	end else begin
		test_done <= 1'b0;
		case (phase)
		P_IDLE: begin
			if (test_run) begin
				phase <= P_WRITE;
				req <= 1'b1;
				wr <= 1'b1;
				cnt <= '0;
				chk_cnt <= '0;
				test_fail <= 1'b0;
			end
		end
		P_WRITE: begin
			if (req && ack) begin
				cnt <= last_wr ? '0 : cnt + CW'(1);
				if (last_wr) begin
					phase <= P_READ;
					wr <= 1'b0;
				end
			end
		end
		P_READ: begin
			if (req && ack) begin
				cnt <= cnt + CW'(1);
				if (cnt == CW'(NBURST - 1))
					req <= 1'b0;
			end
			if (valid) begin
				chk_cnt <= chk_cnt + CW'(1);
				if (rdata != exp_word)
					test_fail <= 1'b1;
				if (chk_cnt == CW'(TEST_WORDS - 1)) begin
					test_done <= 1'b1;
					phase <= P_IDLE;
				end
			end
		end
		default: phase <= P_IDLE;
		endcase
	end
end

always_ff @(posedge CLOCK_50) begin
	if (start)
		addr <= TEST_BASE;
	else if (phase == P_WRITE && req && ack)
		addr <= last_wr ? TEST_BASE : addr + AW'(1);
	else if (phase == P_READ && req && ack)
		addr <= addr + AW'(BURST);

	// Expected address walks with the returned words
	if (start)
		chk_addr <= TEST_BASE;
	else if (valid)
		chk_addr <= chk_addr + AW'(1);
end

endmodule

//--- fb_nano.sv
// Video memory subsystem top
`timescale 1ns/10ps
module fb_nano import mem_pkg::*, video_pkg::*; #(
	parameter int AW = mem_pkg::AW,
	parameter int DW = mem_pkg::DW,
	parameter int BURST = mem_pkg::BURST,
	parameter logic [AW-1:0] FB_BASE = video_pkg::FB_BASE,
	parameter int FB_WORDS = video_pkg::FB_WORDS,
	parameter logic [AW-1:0] TEST_BASE = video_pkg::TEST_BASE,
	parameter int TEST_WORDS = video_pkg::TEST_WORDS
) (
	input logic CLOCK_50,
	input logic rst,
	input logic pix_valid,
	input logic [AW-1:0] pix_addr,
	input logic [23:0] pix_rgb,
	output logic pix_ready,
	input logic scan_start,
	output logic scan_busy,
	output logic out_valid,
	output logic [23:0] out_rgb,
	output logic out_last,
	input logic test_run,
	output logic test_done,
	output logic test_fail
);

// Enough words to hold the frame and test regions apart
localparam int DEPTH_LOG2 = 10;

logic [NCLIENT-1:0] req;
logic [NCLIENT-1:0] wr;
logic [NCLIENT-1:0] ack;
logic [NCLIENT-1:0] valid;
logic [NCLIENT-1:0][AW-1:0] addr;
logic [NCLIENT-1:0][DW-1:0] wdata;
logic [DW-1:0] rdata;

logic [AW-1:0] arr_addr;
logic arr_we;
logic [DW-1:0] arr_wdata;
logic [DW-1:0] arr_rdata;

memory #(.AW(AW), .DW(DW), .BURST(BURST), .NCLIENT(NCLIENT)) i_memory (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.req(req), .wr(wr), .addr(addr), .wdata(wdata),
	.ack(ack), .valid(valid), .rdata(rdata),
	.arr_addr(arr_addr), .arr_we(arr_we), .arr_wdata(arr_wdata),
	.arr_rdata(arr_rdata));

mem_array #(.AW(AW), .DW(DW), .DEPTH_LOG2(DEPTH_LOG2)) i_mem_array (
	.CLOCK_50(CLOCK_50),
	.arr_addr(arr_addr), .arr_we(arr_we), .arr_wdata(arr_wdata),
	.arr_rdata(arr_rdata));

// Scan reader only reads
assign wr[CL_SCAN] = 1'b0;
assign wdata[CL_SCAN] = '0;

scan_reader #(.AW(AW), .DW(DW), .BURST(BURST), .FB_BASE(FB_BASE), .FB_WORDS(FB_WORDS))
	i_scan_reader (
	.CLOCK_50(CLOCK_50), .rst(rst), .scan_start(scan_start),
	.ack(ack[CL_SCAN]), .valid(valid[CL_SCAN]), .rdata(rdata),
	.req(req[CL_SCAN]), .addr(addr[CL_SCAN]),
	.scan_busy(scan_busy), .out_valid(out_valid), .out_rgb(out_rgb),
	.out_last(out_last));

pixel_writer #(.AW(AW), .DW(DW)) i_pixel_writer (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.pix_valid(pix_valid), .pix_addr(pix_addr), .pix_rgb(pix_rgb),
	.ack(ack[CL_PIX]), .pix_ready(pix_ready),
	.req(req[CL_PIX]), .wr(wr[CL_PIX]), .addr(addr[CL_PIX]), .wdata(wdata[CL_PIX]));

mem_test #(.AW(AW), .DW(DW), .BURST(BURST), .TEST_BASE(TEST_BASE),
	.TEST_WORDS(TEST_WORDS)) i_mem_test (
	.CLOCK_50(CLOCK_50), .rst(rst), .test_run(test_run),
	.ack(ack[CL_TEST]), .valid(valid[CL_TEST]), .rdata(rdata),
	.req(req[CL_TEST]), .wr(wr[CL_TEST]), .addr(addr[CL_TEST]),
	.wdata(wdata[CL_TEST]), .test_done(test_done), .test_fail(test_fail));

endmodule

//--- tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
module tb_clock #(
	parameter int PERIOD = 8,
	parameter int RST_CYCLES = 4
) (
	output logic CLOCK_50,
	output logic rst
);

initial begin
	CLOCK_50 = 1'b0;
	forever #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;
end

// Reset held over a fixed count of rising edges
initial begin
	rst = 1'b1;
	repeat (RST_CYCLES) @(posedge CLOCK_50);
	rst <= 1'b0;
end

endmodule

//--- tb_fb_nano.sv
// Video memory subsystem testbench
`timescale 1ns/10ps
module tb_fb_nano import mem_pkg::*, video_pkg::*;;

localparam int PERIOD = 8;
localparam int BURST_PIXELS = 32;
localparam int OVERLAP_PIXELS = 40;
localparam int CYCLES_PER_WORD = 16;
// Words moved by all five tests together
localparam int TOTAL_WORDS = 5 * FB_WORDS + BURST_PIXELS + OVERLAP_PIXELS + 4 * TEST_WORDS;
localparam int TIMEOUT_NS = TOTAL_WORDS * CYCLES_PER_WORD * PERIOD;

logic CLOCK_50;
logic rst;
logic pix_valid;
logic [AW-1:0] pix_addr;
logic [23:0] pix_rgb;
logic pix_ready;
logic scan_start;
logic scan_busy;
logic out_valid;
logic [23:0] out_rgb;
logic out_last;
logic test_run;
logic test_done;
logic test_fail;

// Frame model with one stored RGB565 word per frame address
logic [15:0] model [FB_WORDS];
int errors = 0;
int tests = 0;
int passed = 0;

tb_clock #(.PERIOD(PERIOD), .RST_CYCLES(4)) i_tb_clock (.CLOCK_50(CLOCK_50), .rst(rst));

fb_nano #(.AW(AW), .DW(DW), .BURST(BURST), .FB_BASE(FB_BASE), .FB_WORDS(FB_WORDS),
	.TEST_BASE(TEST_BASE), .TEST_WORDS(TEST_WORDS)) i_fb_nano (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.pix_valid(pix_valid), .pix_addr(pix_addr), .pix_rgb(pix_rgb), .pix_ready(pix_ready),
	.scan_start(scan_start), .scan_busy(scan_busy), .out_valid(out_valid),
	.out_rgb(out_rgb), .out_last(out_last),
	.test_run(test_run), .test_done(test_done), .test_fail(test_fail));

// Top bits of each 8-bit channel
function automatic logic [15:0] to_565(input logic [23:0] rgb);
	return {rgb[23:19], rgb[15:10], rgb[7:3]};
endfunction

// Each channel refilled with copies of its own top bits
function automatic logic [23:0] to_888(input logic [15:0] w);
	return {w[15:11], w[15:13], w[10:5], w[10:9], w[4:0], w[4:2]};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected) begin
		errors++;
		$display("mismatch %s expected %h actual %h", name, expected, actual);
	end
endtask

task automatic report_test(input string name, input int start_errs);
	tests++;
	if (errors == start_errs) begin
		passed++;
		$display("%s: pass", name);
	end else
		$display("%s: FAILED with %0d errors", name, errors - start_errs);
endtask

// Record every pixel that moves across the input handshake
always @(posedge CLOCK_50) begin
	if (!rst && pix_valid && pix_ready)
		model[int'(pix_addr - FB_BASE)] = to_565(pix_rgb);
end

task automatic send_pixels(input int count, input bit in_order, input bit with_gaps,
	output bit stalled);
	int sent;
	int idx;
	sent = 0;
	stalled = 1'b0;
	while (sent < count) begin
		@(posedge CLOCK_50);
		if (pix_valid && !pix_ready)
			stalled = 1'b1;
		if (pix_valid && pix_ready)
			sent++;
		if (sent == count)
			pix_valid <= 1'b0;
		else if (!pix_valid || pix_ready) begin
			// A held pixel stays until it is taken
			if (with_gaps && $urandom % 3 == 0)
				pix_valid <= 1'b0;
			else begin
				idx = in_order ? sent : int'($urandom % FB_WORDS);
				pix_valid <= 1'b1;
				pix_addr <= FB_BASE + AW'(idx);
				pix_rgb <= 24'($urandom);
			end
		end
	end
endtask

task automatic run_scan(input string name, input bit check_values);
	int n;
	bit done;
	n = 0;
	done = 1'b0;
	@(posedge CLOCK_50);
	scan_start <= 1'b1;
	@(posedge CLOCK_50);
	scan_start <= 1'b0;
	while (!done) begin
		@(posedge CLOCK_50);
		if (out_valid) begin
			if (check_values)
				check_value(name, 32'(to_888(model[n])), 32'(out_rgb));
			n++;
			if (out_last) begin
				done = 1'b1;
				check_value({name, " words"}, 32'(FB_WORDS), 32'(n));
				check_value({name, " busy"}, 32'(0), 32'(scan_busy));
			end else begin
				// Busy holds through every word before the last
				check_value({name, " busy"}, 32'(1), 32'(scan_busy));
				if (n >= FB_WORDS) begin
					errors++;
					$display("%s: no out_last on the final frame word", name);
					done = 1'b1;
				end
			end
		end else if (out_last) begin
			errors++;
			$display("%s: out_last seen without out_valid", name);
		end
	end
endtask

task automatic run_memtest(input string name);
	@(posedge CLOCK_50);
	test_run <= 1'b1;
	@(posedge CLOCK_50);
	test_run <= 1'b0;
	do
		@(posedge CLOCK_50);
	while (!test_done);
	check_value({name, " fail"}, 32'(0), 32'(test_fail));
	// Pulse lasts one cycle only
	@(posedge CLOCK_50);
	check_value({name, " done"}, 32'(0), 32'(test_done));
endtask

// Queue of four writes drains in a few two-cycle memory writes
task automatic settle();
	repeat (16) @(posedge CLOCK_50);
endtask

initial begin
	#(TIMEOUT_NS);
	$display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
	$display("Test failed");
	$finish;
end

initial begin
	int start_errs;
	bit stalled;
	void'($urandom(48));
	pix_valid = 1'b0;
	pix_addr = '0;
	pix_rgb = '0;
	scan_start = 1'b0;
	test_run = 1'b0;
	@(posedge CLOCK_50);
	while (rst)
		@(posedge CLOCK_50);

	start_errs = errors;
	check_value("reset scan_busy", 32'(0), 32'(scan_busy));
	check_value("reset out_valid", 32'(0), 32'(out_valid));
	check_value("reset out_last", 32'(0), 32'(out_last));
	check_value("reset test_done", 32'(0), 32'(test_done));
	check_value("reset test_fail", 32'(0), 32'(test_fail));
	check_value("reset pix_ready", 32'(1), 32'(pix_ready));
	report_test("reset_state", start_errs);

	start_errs = errors;
	send_pixels(FB_WORDS, 1'b1, 1'b1, stalled);
	settle();
	run_scan("fill_and_scan", 1'b1);
	report_test("fill_and_scan", start_errs);

	start_errs = errors;
	send_pixels(BURST_PIXELS, 1'b0, 1'b0, stalled);
	check_value("burst pix_ready low", 32'(1), 32'(stalled));
	settle();
	run_scan("burst_scan", 1'b1);
	report_test("burst_backpressure", start_errs);

	start_errs = errors;
	run_memtest("self_test");
	report_test("self_test", start_errs);

	start_errs = errors;
	fork
		run_scan("overlap_scan", 1'b0);
		send_pixels(OVERLAP_PIXELS, 1'b0, 1'b1, stalled);
		run_memtest("overlap_self_test");
	join
	settle();
	run_scan("overlap_rescan", 1'b1);
	report_test("overlap", start_errs);

	$display("%0d tests run, %0d passed, %0d errors", tests, passed, errors);
	if (errors == 0)
		$display("Test completed successfully");
	else
		$display("Test failed");
	$finish;
end

endmodule

//--- fb_nano.f
mem_pkg.sv
video_pkg.sv
mem_array.sv
memory.sv
pixel_writer.sv
scan_reader.sv
mem_test.sv
fb_nano.sv
tb_clock.sv
tb_fb_nano.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fb_nano
FILELIST ?= fb_nano.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing -j 0
PASS_MSG ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
